// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // processor and memory bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // address split: tag | index | word | byte
   localparam int TAG_W = 5;
   localparam int INDEX_W = 8;
   localparam int WORD_SEL_W = 2;

   // cache geometry
   localparam int WORDS_PER_BLOCK = 4;
   localparam int NUM_LINES = 256;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [WORD_SEL_W-1:0] word_sel_t;

   // controller FSM, write-back walk before fetch walk
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WB_REQ,
      WB_DROP,
      FETCH_REQ,
      FETCH_DROP,
      RESPOND,
      WAIT_DROP
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/cache_array_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_array_if
   import cache_pkg::*;
();

   // lookup address, driven by the controller
   index_t    index;
   word_sel_t word_sel;

   // update strobes and payload
   logic      wr_word;
   data_t     wr_data;
   tag_t      set_tag;
   logic      fill;
   logic      mark_dirty;

   // combinational lookup results
   tag_t      rd_tag;
   logic      rd_valid;
   logic      rd_dirty;
   data_t     rd_data;

   modport ctrl (
      output index, word_sel, wr_word, wr_data, set_tag, fill, mark_dirty,
      input  rd_tag, rd_valid, rd_dirty, rd_data
   );

   modport array (
      input  index, word_sel, wr_word, wr_data, set_tag, fill, mark_dirty,
      output rd_tag, rd_valid, rd_dirty, rd_data
   );

endinterface

`default_nettype wire

// ==== design/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_array
   import cache_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   cache_array_if.array arr
);

   // per-line status bits
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // per-line tag and block storage
   tag_t  tag_mem [NUM_LINES];
   data_t data_mem [NUM_LINES][WORDS_PER_BLOCK];

   // zero-cycle lookup at the addressed line and word
   assign arr.rd_tag   = tag_mem[arr.index];
   assign arr.rd_valid = valid_q[arr.index];
   assign arr.rd_dirty = dirty_q[arr.index];
   assign arr.rd_data  = data_mem[arr.index][arr.word_sel];

   // valid and dirty
   // fill makes the line valid and clean
   // mark_dirty flags a write hit for later write-back
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (arr.fill) begin
            valid_q[arr.index] <= 1'b1;
            dirty_q[arr.index] <= 1'b0;
         end
         if (arr.mark_dirty) begin
            dirty_q[arr.index] <= 1'b1;
         end
      end
   end

   // new tag lands with the last fetched word
   always_ff @(posedge clk) begin
      if (arr.fill) begin
         tag_mem[arr.index] <= arr.set_tag;
      end
   end

   // one word per cycle, from a write hit or a fetch
   always_ff @(posedge clk) begin
      if (arr.wr_word) begin
         data_mem[arr.index][arr.word_sel] <= arr.wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== design/cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_controller
   import cache_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   // processor port, four-phase
   input  logic        cpu_req,
   input  logic        cpu_we,
   input  addr_t       cpu_addr,
   input  data_t       cpu_wdata,
   output logic        cpu_ack,
   output logic        cpu_err,
   output data_t       cpu_rdata,

   // memory port, one word per handshake
   output logic        mem_req,
   output logic        mem_we,
   output addr_t       mem_addr,
   output data_t       mem_wdata,
   input  logic        mem_ack,
   input  data_t       mem_rdata,

   cache_array_if.ctrl arr
);

   ctrl_state_t state;
   word_sel_t   word_cnt;

   // request captured when accepted in IDLE
   addr_t       req_addr;
   logic        req_we;
   data_t       req_wdata;

   // response payload
   data_t       rdata_q;
   logic        err_q;

   tag_t        req_tag;
   index_t      req_index;
   word_sel_t   req_word;
   logic        hit;
   logic        last_word;
   logic        in_wb;
   logic        in_walk;

   // address fields of the held request
   assign req_tag   = req_addr[15:11];
   assign req_index = req_addr[10:3];
   assign req_word  = req_addr[2:1];

   assign hit       = arr.rd_valid && (arr.rd_tag == req_tag);
   assign last_word = (word_cnt == word_sel_t'(WORDS_PER_BLOCK - 1));
   assign in_wb     = (state == WB_REQ) || (state == WB_DROP);
   assign in_walk   = in_wb || (state == FETCH_REQ) || (state == FETCH_DROP);

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         word_cnt <= '0;
         err_q    <= 1'b0;
      end else begin
         unique case (state)
            IDLE: begin
               if (cpu_req) begin
                  // odd byte address skips the lookup
                  err_q <= cpu_addr[0];
                  state <= cpu_addr[0] ? RESPOND : COMPARE;
               end
            end
            COMPARE: begin
               word_cnt <= '0;
               if (hit) begin
                  state <= RESPOND;
               end else if (arr.rd_valid && arr.rd_dirty) begin
                  state <= WB_REQ;
               end else begin
                  state <= FETCH_REQ;
               end
            end
            WB_REQ: begin
               if (mem_ack) begin
                  state <= WB_DROP;
               end
            end
            WB_DROP: begin
               // word done once ack has fallen
               if (!mem_ack) begin
                  word_cnt <= word_cnt + word_sel_t'(1);
                  state    <= last_word ? FETCH_REQ : WB_REQ;
               end
            end
            FETCH_REQ: begin
               if (mem_ack) begin
                  state <= FETCH_DROP;
               end
            end
            FETCH_DROP: begin
               // block complete, retry the lookup which now hits
               if (!mem_ack) begin
                  word_cnt <= word_cnt + word_sel_t'(1);
                  state    <= last_word ? COMPARE : FETCH_REQ;
               end
            end
            RESPOND: begin
               state <= WAIT_DROP;
            end
            WAIT_DROP: begin
               if (!cpu_req) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && cpu_req) begin
         req_addr  <= cpu_addr;
         req_we    <= cpu_we;
         req_wdata <= cpu_wdata;
      end
      // read hit data held through the ack phase
      if (state == COMPARE && hit && !req_we) begin
         rdata_q <= arr.rd_data;
      end
   end

   // array control
   always_comb begin
      arr.index      = req_index;
      arr.word_sel   = in_walk ? word_cnt : req_word;
      arr.set_tag    = req_tag;
      arr.wr_word    = 1'b0;
      arr.wr_data    = req_wdata;
      arr.fill       = 1'b0;
      arr.mark_dirty = 1'b0;
      if (state == COMPARE && hit && req_we) begin
         arr.wr_word    = 1'b1;
         arr.mark_dirty = 1'b1;
      end
      // fetched word captured while mem_ack is high
      if (state == FETCH_REQ && mem_ack) begin
         arr.wr_word = 1'b1;
         arr.wr_data = mem_rdata;
         arr.fill    = last_word;
      end
   end

   // memory port decoded from state
   // victim address built from the stored tag, which is unchanged until fill
   assign mem_req   = (state == WB_REQ) || (state == FETCH_REQ);
   assign mem_we    = in_wb;
   assign mem_addr  = {(in_wb ? arr.rd_tag : req_tag), req_index, word_cnt, 1'b0};
   assign mem_wdata = arr.rd_data;

   // processor response
   assign cpu_ack   = (state == WAIT_DROP);
   assign cpu_err   = err_q;
   assign cpu_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== design/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top
   import cache_pkg::*;
(
   input  logic  clk,
   input  logic  rst,

   // processor side
   input  logic  cpu_req,
   input  logic  cpu_we,
   input  addr_t cpu_addr,
   input  data_t cpu_wdata,
   output logic  cpu_ack,
   output logic  cpu_err,
   output data_t cpu_rdata,

   // main memory side
   output logic  mem_req,
   output logic  mem_we,
   output addr_t mem_addr,
   output data_t mem_wdata,
   input  logic  mem_ack,
   input  data_t mem_rdata
);

   // controller to storage
   cache_array_if arr_if ();

   cache_controller cache_controller_i (
      .clk       (clk),
      .rst       (rst),
      .cpu_req   (cpu_req),
      .cpu_we    (cpu_we),
      .cpu_addr  (cpu_addr),
      .cpu_wdata (cpu_wdata),
      .cpu_ack   (cpu_ack),
      .cpu_err   (cpu_err),
      .cpu_rdata (cpu_rdata),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .arr       (arr_if.ctrl)
   );

   cache_array cache_array_i (
      .clk (clk),
      .rst (rst),
      .arr (arr_if.array)
   );

endmodule

`default_nettype wire

// ==== sim/cache_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_chk
   import cache_pkg::*;
(
   input wire logic  clk,
   input wire logic  rst,
   input wire logic  cpu_req,
   input wire logic  cpu_ack,
   input wire logic  mem_req,
   input wire logic  mem_we,
   input wire addr_t mem_addr,
   input wire logic  mem_ack
);

   // number of failed assertions so far
   int fail_cnt;

   initial fail_cnt = 0;

   // ack only ever answers a live request
   ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(cpu_ack) |-> cpu_req)
      else begin
         $error("cpu_ack rose while cpu_req was low");
         fail_cnt++;
      end

   // no withdrawn memory request
   mem_req_held: assert property (@(posedge clk) disable iff (rst)
      mem_req && !mem_ack |=> mem_req)
      else begin
         $error("mem_req dropped before mem_ack");
         fail_cnt++;
      end

   // address and direction frozen for the whole word
   mem_cmd_stable: assert property (@(posedge clk) disable iff (rst)
      mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we))
      else begin
         $error("mem_addr or mem_we changed while mem_req was high");
         fail_cnt++;
      end

endmodule

bind cache_top cache_chk cache_chk_i (
   .clk      (clk),
   .rst      (rst),
   .cpu_req  (cpu_req),
   .cpu_ack  (cpu_ack),
   .mem_req  (mem_req),
   .mem_we   (mem_we),
   .mem_addr (mem_addr),
   .mem_ack  (mem_ack)
);

`default_nettype wire

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb
   import cache_pkg::*;
();

   localparam int NUM_REQ = 300;
   // one memory word, worst case, plus per-request overhead
   localparam int HS_MAX = 7;
   localparam int TIMEOUT = NUM_REQ * (8 * HS_MAX + 6) + 50;

   logic  clk;
   logic  rst;
   logic  cpu_req;
   logic  cpu_we;
   addr_t cpu_addr;
   data_t cpu_wdata;
   logic  cpu_ack;
   logic  cpu_err;
   data_t cpu_rdata;
   logic  mem_req;
   logic  mem_we;
   addr_t mem_addr;
   data_t mem_wdata;
   logic  mem_ack;
   data_t mem_rdata;

   // main memory contents and the processor's view of every word
   data_t mem_model [32768];
   data_t cur [32768];
   // expected line status
   tag_t  line_tag [NUM_LINES];
   logic  line_valid [NUM_LINES];
   logic  line_dirty [NUM_LINES];
   // memory transfers seen during one request
   logic  log_we [$];
   addr_t log_addr [$];
   data_t log_data [$];
   data_t got_rdata;
   logic  got_err;
   int    err_cnt;
   int    cycles;

   cache_top cache_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // global cycle limit
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the cache stopped answering", cycles);
      $display(">>> FAIL");
      $finish;
   end

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   // memory side, one word per handshake, 0 to 3 cycles of delay
   task automatic respond_mem();
      int unsigned delay;
      logic        we;
      addr_t       addr;
      forever begin
         @(posedge clk);
         if (mem_req) begin
            we = mem_we;
            addr = mem_addr;
            delay = $urandom_range(3, 0);
            repeat (delay) @(posedge clk);
            log_we.push_back(we);
            log_addr.push_back(addr);
            if (we) begin
               mem_model[addr[15:1]] = mem_wdata;
               log_data.push_back(mem_wdata);
            end else begin
               mem_rdata <= mem_model[addr[15:1]];
               log_data.push_back(mem_model[addr[15:1]]);
            end
            mem_ack <= 1'b1;
            // hold ack until the request is gone
            do @(posedge clk); while (mem_req);
            mem_ack <= 1'b0;
         end
      end
   endtask

   // full four-phase processor cycle
   task automatic issue(input logic we, input addr_t addr, input data_t wdata);
      @(posedge clk);
      cpu_req <= 1'b1;
      cpu_we <= we;
      cpu_addr <= addr;
      cpu_wdata <= wdata;
      do @(posedge clk); while (!cpu_ack);
      got_rdata = cpu_rdata;
      got_err = cpu_err;
      cpu_req <= 1'b0;
      do @(posedge clk); while (cpu_ack);
   endtask

   task automatic expect_xfer(input int i, input logic we, input addr_t addr);
      if (i >= log_we.size()) begin
         $display("memory transfer %0d never happened", i);
         err_cnt++;
      end else begin
         check_flag("mem_we", log_we[i], we);
         check_addr("mem_addr", log_addr[i], addr);
         // victim words carry the processor's latest values
         if (we) begin
            check_data("mem_wdata", log_data[i], cur[addr[15:1]]);
         end
      end
   endtask

   task automatic run_one(input int n);
      logic      we;
      logic      odd;
      logic      hit;
      logic      evict;
      tag_t      tag;
      index_t    idx;
      word_sel_t w;
      addr_t     addr;
      data_t     wdata;
      int        start_err;
      int        k;
      // few tags over few lines so evictions are common
      tag = tag_t'($urandom_range(3, 0) * 5 + 2);
      idx = index_t'($urandom_range(3, 0) * 37 + 1);
      w = word_sel_t'($urandom_range(3, 0));
      odd = ($urandom_range(19, 0) == 0);
      we = $urandom_range(1, 0);
      wdata = data_t'($urandom);
      addr = {tag, idx, w, odd};
      start_err = err_cnt;
      log_we.delete();
      log_addr.delete();
      log_data.delete();
      hit = line_valid[idx] && (line_tag[idx] == tag);
      evict = !odd && !hit && line_valid[idx] && line_dirty[idx];
      issue(we, addr, wdata);
      check_flag("cpu_err", got_err, odd);
      k = (odd || hit) ? 0 : (evict ? 8 : 4);
      if (log_we.size() != k) begin
         $display("expected %0d memory transfers but saw %0d", k, log_we.size());
         err_cnt++;
      end
      k = 0;
      // victim first, old tag, word order
      if (evict) begin
         for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            expect_xfer(k, 1'b1, {line_tag[idx], idx, word_sel_t'(i), 1'b0});
            k++;
         end
      end
      if (!odd && !hit) begin
         for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            expect_xfer(k, 1'b0, {tag, idx, word_sel_t'(i), 1'b0});
            k++;
         end
         line_tag[idx] = tag;
         line_valid[idx] = 1'b1;
         line_dirty[idx] = 1'b0;
      end
      if (!odd && we) begin
         cur[addr[15:1]] = wdata;
         line_dirty[idx] = 1'b1;
      end else if (!odd) begin
         check_data("cpu_rdata", got_rdata, cur[addr[15:1]]);
      end
      $display("req %0d %s addr %h %s %s", n, we ? "wr" : "rd", addr,
         odd ? "odd" : (hit ? "hit" : "miss"), (err_cnt == start_err) ? "ok" : "bad");
   endtask

   initial begin
      void'($urandom(32'h65129d15));
      err_cnt = 0;
      rst = 1'b1;
      cpu_req = 1'b0;
      cpu_we = 1'b0;
      cpu_addr = '0;
      cpu_wdata = '0;
      mem_ack = 1'b0;
      mem_rdata = '0;
      for (int i = 0; i < 32768; i++) begin
         mem_model[i] = data_t'($urandom) ^ data_t'(i);
         cur[i] = mem_model[i];
      end
      for (int i = 0; i < NUM_LINES; i++) begin
         line_tag[i] = '0;
         line_valid[i] = 1'b0;
         line_dirty[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // idle outputs straight after reset
      check_flag("cpu_ack", cpu_ack, 1'b0);
      check_flag("cpu_err", cpu_err, 1'b0);
      check_flag("mem_req", mem_req, 1'b0);
      fork
         respond_mem();
      join_none
      for (int n = 0; n < NUM_REQ; n++) begin
         run_one(n);
      end
      err_cnt += cache_top_i.cache_chk_i.fail_cnt;
      $display("%0d requests, %0d errors", NUM_REQ, err_cnt);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
design/cache_pkg.sv
design/cache_array_if.sv
design/cache_array.sv
design/cache_controller.sv
design/cache_top.sv
sim/cache_chk.sv
sim/cache_tb.sv
